//--- Bender.yml
package:
  name: gb_cpu

sources:
  - source/gb_pkg.sv
  - source/gb_ifs.sv
  - source/gb_alu.sv
  - source/gb_regfile.sv
  - source/gb_decoder.sv
  - source/gb_sequencer.sv
  - source/gb_cpu.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_gb_cpu.sv

//--- sim/gb_tb_vectors.svh
// Stimulus table for the CPU testbench, one row per test program.
// Included inside the testbench module after the package import.
`ifndef GB_TB_VECTORS_SVH
`define GB_TB_VECTORS_SVH

localparam logic [2:0] K_ALU_R = 3'd0, K_ALU_D8 = 3'd1, K_INCDEC = 3'd2, K_PAIRS = 3'd3;
localparam logic [2:0] K_CHAIN = 3'd4, K_JR = 3'd5, K_JP = 3'd6;
localparam int NUM_FIXED = 22;
localparam int NUM_VECTORS = 44;	// second half random, same kinds

typedef struct packed {
	logic [2:0] kind;
	alu_op_t    op;	// alu op, inc/dec or jump condition
	reg_sel_t   rsel;	// inc/dec target
	byte_t      a;
	byte_t      b;
	logic       cin;	// carry set up before the op
	addr_t      where;	// ldh offset, or SP for the pair test
	byte_t      exp_res;
	flags_t     exp_flags;
} vector_t;

vector_t vectors [NUM_VECTORS];

task automatic load_fixed_vectors();
	vectors[0] = '{K_ALU_R, ALU_ADD, REG_B, 8'h0F, 8'h01, 1'b1, 16'h0080, 8'h10, 4'b0010};
	vectors[1] = '{K_ALU_D8, ALU_ADD, REG_B, 8'hFF, 8'h01, 1'b0, 16'h0081, 8'h00, 4'b1011};
	vectors[2] = '{K_ALU_R, ALU_ADC, REG_B, 8'h0E, 8'h01, 1'b1, 16'h0082, 8'h10, 4'b0010};
	vectors[3] = '{K_ALU_D8, ALU_SUB, REG_B, 8'h10, 8'h01, 1'b1, 16'h0083, 8'h0F, 4'b0110};
	vectors[4] = '{K_ALU_R, ALU_SBC, REG_B, 8'h00, 8'h00, 1'b1, 16'h0084, 8'hFF, 4'b0111};
	vectors[5] = '{K_ALU_D8, ALU_AND, REG_B, 8'hF0, 8'h0F, 1'b0, 16'h0085, 8'h00, 4'b1010};
	vectors[6] = '{K_ALU_R, ALU_XOR, REG_B, 8'h5A, 8'h5A, 1'b1, 16'h0086, 8'h00, 4'b1000};
	vectors[7] = '{K_ALU_D8, ALU_OR, REG_B, 8'h50, 8'h0A, 1'b0, 16'h0087, 8'h5A, 4'b0000};
	vectors[8] = '{K_ALU_R, ALU_CP, REG_B, 8'h3C, 8'h40, 1'b0, 16'h0088, 8'h3C, 4'b0101};
	vectors[9] = '{K_ALU_D8, ALU_CP, REG_B, 8'h42, 8'h42, 1'b1, 16'h0089, 8'h42, 4'b1100};
	vectors[10] = '{K_INCDEC, ALU_INC, REG_B, 8'h0F, 8'h00, 1'b1, 16'h008A, 8'h10, 4'b0011};
	vectors[11] = '{K_INCDEC, ALU_DEC, REG_L, 8'h10, 8'h00, 1'b0, 16'h008B, 8'h0F, 4'b0110};
	vectors[12] = '{K_INCDEC, ALU_INC, REG_A, 8'hFF, 8'h00, 1'b0, 16'h008C, 8'h00, 4'b1010};
	vectors[13] = '{K_INCDEC, ALU_DEC, REG_C, 8'h01, 8'h00, 1'b1, 16'h008D, 8'h00, 4'b1101};
	vectors[14] = '{K_PAIRS, ALU_ADD, REG_B, 8'h12, 8'h34, 1'b0, 16'hD000, 8'h00, 4'b0000};
	vectors[15] = '{K_CHAIN, ALU_ADD, REG_B, 8'hA7, 8'h00, 1'b0, 16'h0090, 8'hA7, 4'b0000};
	vectors[16] = '{K_JR, {1'b0, COND_NZ}, REG_B, 8'h10, 8'h20, 1'b0, 16'h0091, 8'hAA, 4'b0};
	vectors[17] = '{K_JR, {1'b0, COND_Z}, REG_B, 8'h33, 8'h33, 1'b0, 16'h0092, 8'hAA, 4'b0};
	vectors[18] = '{K_JR, {1'b0, COND_NC}, REG_B, 8'h10, 8'h20, 1'b0, 16'h0093, 8'h55, 4'b0};
	vectors[19] = '{K_JP, {1'b0, COND_C}, REG_B, 8'h10, 8'h20, 1'b0, 16'h0094, 8'hAA, 4'b0};
	vectors[20] = '{K_JP, {1'b0, COND_NZ}, REG_B, 8'h44, 8'h44, 1'b0, 16'h0095, 8'h55, 4'b0};
	vectors[21] = '{K_JR, {1'b0, COND_ALWAYS}, REG_B, 8'h01, 8'h02, 1'b0, 16'h0096, 8'hAA, 4'b0};
endtask

`endif

//--- sim/tb_gb_cpu.sv
// Testbench for the CPU core: builds a short program per table row, resets,
// runs to halt and checks the bus reads, the bus writes and the halted pc.
`timescale 1ns/1ps

module tb_gb_cpu;
	import gb_pkg::*;

	`include "gb_tb_vectors.svh"

	localparam int HALT_TIMEOUT = 400;	// clocks

	logic  clock;
	logic  rst;
	addr_t addr;
	byte_t data_in;
	byte_t data_out;
	logic  re;
	logic  we;
	addr_t pc;
	logic  halted;

	byte_t       mem [65536];
	addr_t       wr_addr_q [$];
	byte_t       wr_data_q [$];
	addr_t       exp_addr_q [$];
	byte_t       exp_data_q [$];
	addr_t       rd_addr_q [$];
	addr_t       exp_rd_q [$];
	logic        we_last;
	logic        re_last;
	addr_t       prog_len;
	addr_t       exp_pc;	// jump tests only

	gb_cpu i_gb_cpu (.clock, .rst, .addr, .data_in, .data_out, .re, .we, .pc, .halted);

	assign data_in = mem[addr];	// memory answers at once

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// one entry per rising edge of re or we
	always @(negedge clock) begin
		if (re && !re_last)
			rd_addr_q.push_back(addr);
		if (we && !we_last) begin
			wr_addr_q.push_back(addr);
			wr_data_q.push_back(data_out);
		end
		re_last = re;
		we_last = we;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp)
			stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp)
			stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_flags(input string name, input flags_t exp, input flags_t act);
		if (act !== exp)
			stop_on_error($sformatf("Mismatch %s: expected znhc %b, actual %b", name, exp, act));
	endtask

	function automatic string kind_name(input logic [2:0] kind);
		case (kind)
			K_ALU_R:  return "alu_r";
			K_ALU_D8: return "alu_d8";
			K_INCDEC: return "incdec";
			K_PAIRS:  return "pairs";
			K_CHAIN:  return "chain";
			K_JR:     return "jr";
			default:  return "jp";
		endcase
	endfunction

	// reference arithmetic, Z N H C
	task automatic alu_model(input alu_op_t op, input byte_t a, input byte_t b, input logic cin,
		output byte_t res, output flags_t f);
		int   full;
		int   low;
		int   ci;
		logic n;
		logic h;
		logic c;
		n = 1'b0;
		h = 1'b0;
		c = 1'b0;
		low = 0;
		ci = (op == ALU_ADC || op == ALU_SBC) ? int'(cin) : 0;
		case (op)
			ALU_ADD, ALU_ADC: begin
				full = int'(a) + int'(b) + ci;
				low = int'(a[3:0]) + int'(b[3:0]) + ci;
				h = low > 15;
				c = full > 255;
			end
			ALU_SUB, ALU_SBC, ALU_CP: begin
				full = int'(a) - int'(b) - ci;
				low = int'(a[3:0]) - int'(b[3:0]) - ci;
				n = 1'b1;
				h = low < 0;
				c = full < 0;
			end
			ALU_AND: begin
				full = int'(a & b);
				h = 1'b1;
			end
			ALU_XOR: full = int'(a ^ b);
			ALU_OR:  full = int'(a | b);
			ALU_INC: begin
				full = int'(a) + 1;
				h = a[3:0] == 4'hF;
				c = cin;
			end
			default: begin	// dec
				full = int'(a) - 1;
				n = 1'b1;
				h = a[3:0] == 4'h0;
				c = cin;
			end
		endcase
		res = full[7:0];
		f = {res == 8'h00, n, h, c};
		if (op == ALU_CP)
			res = a;	// A is left alone
	endtask

	// flags after cp a,b decide the branch
	function automatic logic jump_taken(input logic [2:0] cond, input byte_t a, input byte_t b);
		case (cond)
			COND_NZ: return a != b;
			COND_Z:  return a == b;
			COND_NC: return a >= b;
			COND_C:  return a < b;
			default: return 1'b1;
		endcase
	endfunction

	task automatic load_random_vectors();
		vector_t     v;
		int unsigned rnd;
		int unsigned rnd2;
		int unsigned pick;
		for (int i = NUM_FIXED; i < NUM_VECTORS; i++) begin
			v = '0;
			rnd = $urandom;
			rnd2 = $urandom;
			v.kind = vectors[i - NUM_FIXED].kind;
			v.a = rnd[7:0];
			v.b = rnd[15:8];
			v.cin = rnd[16];
			v.rsel = (rnd[19:17] == REG_NONE) ? REG_A : rnd[19:17];
			v.where = {8'h00, 2'b10, rnd[25:20]};
			case (v.kind)
				K_ALU_R, K_ALU_D8: begin
					v.op = {1'b0, rnd[28:26]};
					alu_model(v.op, v.a, v.b, v.cin, v.exp_res, v.exp_flags);
				end
				K_INCDEC: begin
					v.op = rnd[29] ? ALU_DEC : ALU_INC;
					alu_model(v.op, v.a, 8'h00, v.cin, v.exp_res, v.exp_flags);
				end
				K_PAIRS: v.where = {4'hC, rnd2[15:4]};
				K_CHAIN: v.exp_res = v.a;
				default: begin
					pick = rnd2 % 5;
					v.op = pick[3:0];
					v.exp_res = jump_taken(v.op[2:0], v.a, v.b) ? 8'hAA : 8'h55;
				end
			endcase
			vectors[i] = v;
		end
	endtask

	task automatic emit(input byte_t b);
		mem[prog_len] = b;
		prog_len = prog_len + 16'd1;
	endtask

	task automatic expect_write(input addr_t a, input byte_t d);
		exp_addr_q.push_back(a);
		exp_data_q.push_back(d);
	endtask

	// every address from first to last is fetched once, in order
	task automatic expect_reads(input addr_t first, input addr_t last);
		for (int a = int'(first); a <= int'(last); a++)
			exp_rd_q.push_back(a[15:0]);
	endtask

	// ld A,m ; ldh (ofs),A ; halt
	task automatic emit_marker(input byte_t m, input byte_t ofs);
		emit(8'h3E);
		emit(m);
		emit(8'hE0);
		emit(ofs);
		emit(8'h76);
	endtask

	task automatic build_program(input vector_t v);
		byte_t ofs;
		addr_t nt_halt;
		addr_t t_halt;
		prog_len = '0;
		exp_addr_q = {};
		exp_data_q = {};
		exp_rd_q = {};
		exp_pc = '0;
		ofs = v.where[7:0];
		case (v.kind)
			K_ALU_R, K_ALU_D8, K_INCDEC: begin
				emit(8'h3E);	// A=0, cp sets the carry
				emit(8'h00);
				emit(8'hFE);
				emit({7'd0, v.cin});
				if (v.kind == K_INCDEC) begin
					emit({2'b00, v.rsel, 3'b110});
					emit(v.a);
					emit({2'b00, v.rsel, 2'b10, v.op == ALU_DEC});
					emit({5'b01111, v.rsel});	// copy to A
				end else begin
					emit(8'h3E);
					emit(v.a);
					emit(8'h06);
					emit((v.kind == K_ALU_R) ? v.b : ~v.b);	// B differs from d8
					if (v.kind == K_ALU_R) begin
						emit({2'b10, v.op[2:0], 3'b000});
					end else begin
						emit({2'b11, v.op[2:0], 3'b110});
						emit(v.b);
					end
				end
				emit(8'hE0);
				emit(ofs);
				emit(8'hF5);
				emit(8'h76);
				expect_write({HIGH_PAGE, ofs}, v.exp_res);
				expect_write(16'hFFFD, v.exp_res);
				expect_write(16'hFFFC, {v.exp_flags, 4'h0});
			end
			K_PAIRS: begin
				emit(8'h31);
				emit(v.where[7:0]);
				emit(v.where[15:8]);
				emit(8'h01);	// B=a C=b
				emit(v.b);
				emit(v.a);
				emit(8'h11);	// D=b E=a
				emit(v.a);
				emit(v.b);
				emit(8'h21);	// H=~a L=~b
				emit(~v.b);
				emit(~v.a);
				emit(8'hC5);
				emit(8'hD5);
				emit(8'hE5);
				emit(8'h76);
				expect_write(v.where - 16'd1, v.a);
				expect_write(v.where - 16'd2, v.b);
				expect_write(v.where - 16'd3, v.b);
				expect_write(v.where - 16'd4, v.a);
				expect_write(v.where - 16'd5, ~v.a);
				expect_write(v.where - 16'd6, ~v.b);
			end
			K_CHAIN: begin
				emit(8'h06);
				emit(v.a);
				emit(8'h48);	// B to C to D to E to H to L to A
				emit(8'h51);
				emit(8'h5A);
				emit(8'h63);
				emit(8'h6C);
				emit(8'h7D);
				emit(8'hE0);
				emit(ofs);
				emit(8'h76);
				expect_write({HIGH_PAGE, ofs}, v.a);
			end
			default: begin	// cp, then jr or jp to the second marker
				emit(8'h3E);
				emit(v.a);
				emit(8'hFE);
				emit(v.b);
				if (v.kind == K_JR) begin
					emit(v.op[2:0] == COND_ALWAYS ? 8'h18 : {3'b001, v.op[1:0], 3'b000});
					emit(8'h05);
				end else begin
					emit(v.op[2:0] == COND_ALWAYS ? 8'hC3 : {3'b110, v.op[1:0], 3'b010});
					emit(8'h0C);
					emit(8'h00);
				end
				emit_marker(8'h55, ofs);
				nt_halt = prog_len - 16'd1;
				emit_marker(8'hAA, ofs);
				t_halt = prog_len - 16'd1;
				expect_write({HIGH_PAGE, ofs}, v.exp_res);
				exp_pc = ((v.exp_res == 8'hAA) ? t_halt : nt_halt) + 16'd1;
				expect_reads(16'd0, nt_halt - 16'd5);	// up to the jump
				expect_reads(exp_pc - 16'd5, exp_pc - 16'd1);	// marker path
			end
		endcase
		if (v.kind != K_JR && v.kind != K_JP)
			expect_reads(16'd0, prog_len - 16'd1);
	endtask

	task automatic check_reads(input string name);
		if (rd_addr_q.size() != exp_rd_q.size())
			stop_on_error($sformatf("%s: saw %0d bus reads where %0d were due", name,
				rd_addr_q.size(), exp_rd_q.size()));
		for (int i = 0; i < exp_rd_q.size(); i++)
			check_addr(name, exp_rd_q[i], rd_addr_q[i]);
	endtask

	task automatic check_writes(input string name, input vector_t v);
		byte_t f_byte;
		if (wr_addr_q.size() != exp_addr_q.size())
			stop_on_error($sformatf("%s: saw %0d bus writes where %0d were due", name,
				wr_addr_q.size(), exp_addr_q.size()));
		if (v.kind == K_ALU_R || v.kind == K_ALU_D8 || v.kind == K_INCDEC) begin
			f_byte = wr_data_q[2];
			check_flags(name, v.exp_flags, f_byte[7:4]);
		end
		for (int i = 0; i < exp_addr_q.size(); i++) begin
			check_addr(name, exp_addr_q[i], wr_addr_q[i]);
			check_byte(name, exp_data_q[i], wr_data_q[i]);
		end
		if (v.kind == K_JR || v.kind == K_JP)
			check_addr(name, exp_pc, pc);
	endtask

	task automatic run_vector(input int idx);
		vector_t v;
		string   name;
		int      cycles;
		v = vectors[idx];
		name = $sformatf("%s_%0d", kind_name(v.kind), idx);
		@(posedge clock);
		rst <= 1'b1;
		build_program(v);
		wr_addr_q = {};
		wr_data_q = {};
		rd_addr_q = {};
		repeat (3) @(posedge clock);
		rst <= 1'b0;
		cycles = 0;
		while (!halted) begin
			@(negedge clock);
			cycles++;
			if (cycles > HALT_TIMEOUT)
				stop_on_error($sformatf("%s: CPU did not halt within %0d clocks", name,
					HALT_TIMEOUT));
		end
		check_reads(name);
		check_writes(name, v);
	endtask

	initial begin
		rst = 1'b1;
		we_last = 1'b0;
		re_last = 1'b0;
		void'($urandom(21));
		for (int i = 0; i < 65536; i++)
			mem[i] = i[15:8] ^ i[7:0];
		load_fixed_vectors();
		load_random_vectors();
		for (int i = 0; i < NUM_VECTORS; i++)
			run_vector(i);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- source/gb_alu.sv
// 8-bit ALU with registered result and Z N H C flags.
// Operands presented on one clock give result and flags after that edge.
`timescale 1ns/1ps

module gb_alu (
	input logic clock,
	input logic rst,
	gb_alu_if.alu alu
);
	import gb_pkg::*;

	byte_t      opb;
	logic       cin;
	logic [8:0] add9, sub9;
	logic [4:0] add5, sub5;
	byte_t      res;
	logic       h, c, n;

	always_comb begin
		opb = (alu.op == ALU_INC || alu.op == ALU_DEC) ? 8'd1 : alu.b;
		cin = (alu.op == ALU_ADC || alu.op == ALU_SBC) ? alu.carry_in : 1'b0;
		add9 = {1'b0, alu.a} + {1'b0, opb} + {8'd0, cin};
		add5 = {1'b0, alu.a[3:0]} + {1'b0, opb[3:0]} + {4'd0, cin};
		sub9 = {1'b0, alu.a} - {1'b0, opb} - {8'd0, cin};	// bit 8 is the borrow
		sub5 = {1'b0, alu.a[3:0]} - {1'b0, opb[3:0]} - {4'd0, cin};
		n = 1'b0;
		case (alu.op)
			ALU_ADD, ALU_ADC, ALU_INC: begin
				res = add9[7:0];
				h = add5[4];
				c = add9[8];
			end
			ALU_AND: begin
				res = alu.a & opb;
				h = 1'b1;
				c = 1'b0;
			end
			ALU_XOR: begin
				res = alu.a ^ opb;
				h = 1'b0;
				c = 1'b0;
			end
			ALU_OR: begin
				res = alu.a | opb;
				h = 1'b0;
				c = 1'b0;
			end
			default: begin	// sub, sbc, cp, dec
				res = sub9[7:0];
				h = sub5[4];
				c = sub9[8];
				n = 1'b1;
			end
		endcase
		if (alu.op == ALU_INC || alu.op == ALU_DEC)
			c = alu.carry_in;	// inc/dec keep carry
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			alu.result <= '0;
			alu.znhc <= '0;
		end else begin
			alu.result <= res;
			alu.znhc <= {res == 8'd0, n, h, c};
		end
	end

endmodule

//--- source/gb_cpu.sv
// Top level of the CPU core: decoder, sequencer, register file and ALU.
// Memory answers data_in combinationally from addr.
`timescale 1ns/1ps

module gb_cpu (
	input  logic          clock,
	input  logic          rst,
	output gb_pkg::addr_t addr,
	input  gb_pkg::byte_t data_in,
	output gb_pkg::byte_t data_out,
	output logic          re,
	output logic          we,
	output gb_pkg::addr_t pc,
	output logic          halted
);
	import gb_pkg::*;

	byte_t     opcode;
	instr_t    instr;
	reg_sel_t  dst, src;
	pair_sel_t pair;
	alu_op_t   alu_op;
	cond_t     cond;

	gb_reg_if reg_bus ();
	gb_alu_if alu_bus ();

	gb_decoder i_decoder (.opcode, .instr, .dst, .src, .pair, .alu_op, .cond);

	gb_sequencer i_sequencer (.clock, .rst, .instr, .dst, .src, .pair, .alu_op, .cond,
		.opcode, .regs(reg_bus), .alu(alu_bus), .addr, .data_in, .data_out, .re, .we,
		.pc, .halted);

	gb_regfile i_regfile (.clock, .rst, .rf(reg_bus));

	gb_alu i_alu (.clock, .rst, .alu(alu_bus));

endmodule

//--- source/gb_decoder.sv
// Opcode decoder: instruction class plus register, pair, ALU and condition fields.
// Opcodes outside the supported subset decode as nop.
`timescale 1ns/1ps

module gb_decoder (
	input  gb_pkg::byte_t     opcode,
	output gb_pkg::instr_t    instr,
	output gb_pkg::reg_sel_t  dst,
	output gb_pkg::reg_sel_t  src,
	output gb_pkg::pair_sel_t pair,
	output gb_pkg::alu_op_t   alu_op,
	output gb_pkg::cond_t     cond
);
	import gb_pkg::*;

	logic dst_ok, src_ok;

	assign dst = opcode[5:3];
	assign src = opcode[2:0];
	assign pair = opcode[5:4];
	assign dst_ok = opcode[5:3] != REG_NONE;	// (HL) forms are not supported
	assign src_ok = opcode[2:0] != REG_NONE;

	always_comb begin
		instr = I_NOP;
		alu_op = {1'b0, opcode[5:3]};
		cond = {1'b0, opcode[4:3]};
		casez (opcode)
			8'h76: instr = I_HALT;
			8'b00??_?110: if (dst_ok) instr = I_LD_R_D8;
			8'b01??_????: if (dst_ok && src_ok) instr = I_LD_R_R;
			8'b00??_0001: instr = I_LD_RR_D16;
			8'b10??_????: if (src_ok) instr = I_ALU_R;
			8'b11??_?110: instr = I_ALU_D8;
			8'b00??_?10?: begin
				if (dst_ok) instr = I_INCDEC;
				alu_op = opcode[0] ? ALU_DEC : ALU_INC;
			end
			8'hC3: begin
				instr = I_JP;
				cond = COND_ALWAYS;
			end
			8'hC2, 8'hCA, 8'hD2, 8'hDA: instr = I_JP;
			8'h18: begin
				instr = I_JR;
				cond = COND_ALWAYS;
			end
			8'h20, 8'h28, 8'h30, 8'h38: instr = I_JR;
			8'hE0: instr = I_LDH_A8_A;
			8'b11??_0101: instr = I_PUSH;
			default: instr = I_NOP;
		endcase
	end

endmodule

//--- source/gb_ifs.sv
// Internal buses of the CPU core: register file port and ALU port.
`timescale 1ns/1ps

interface gb_reg_if;
	import gb_pkg::*;

	reg_sel_t  rd_sel;
	byte_t     rd_data;
	reg_sel_t  wr_sel;
	byte_t     wr_data;
	logic      wr_en;
	pair_sel_t pair_sel;
	byte_t     pair_hi;
	byte_t     pair_lo;
	logic      pair_en;
	flags_t    flags_wr;
	flags_t    flags_mask;
	logic      flags_en;
	flags_t    flags;
	byte_t     acc;

	modport seq (output rd_sel, wr_sel, wr_data, wr_en, pair_sel, pair_hi, pair_lo, pair_en,
		flags_wr, flags_mask, flags_en, input rd_data, flags, acc);
	modport rf (input rd_sel, wr_sel, wr_data, wr_en, pair_sel, pair_hi, pair_lo, pair_en,
		flags_wr, flags_mask, flags_en, output rd_data, flags, acc);
endinterface

interface gb_alu_if;
	import gb_pkg::*;

	byte_t   a;
	byte_t   b;
	alu_op_t op;
	logic    carry_in;
	byte_t   result;	// valid the clock after issue
	flags_t  znhc;

	modport seq (output a, b, op, carry_in, input result, znhc);
	modport alu (input a, b, op, carry_in, output result, znhc);
endinterface

//--- source/gb_pkg.sv
// Shared types, field encodings and constants for the Game Boy style CPU core.
// Modules import it inside their body; port lists use scoped names.
package gb_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] addr_t;
	typedef logic [3:0]  flags_t;	// Z N H C
	typedef logic [2:0]  reg_sel_t;
	typedef logic [1:0]  pair_sel_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [3:0]  instr_t;
	typedef logic [2:0]  cond_t;
	typedef logic [4:0]  cycle_cnt_t;

	typedef enum logic [1:0] {ST_FETCH, ST_EXEC, ST_HALT} seq_state_t;

	// register selects follow the opcode field
	localparam reg_sel_t REG_B = 3'd0, REG_C = 3'd1, REG_D = 3'd2, REG_E = 3'd3;
	localparam reg_sel_t REG_H = 3'd4, REG_L = 3'd5, REG_NONE = 3'd6, REG_A = 3'd7;

	localparam pair_sel_t PAIR_BC = 2'd0, PAIR_DE = 2'd1, PAIR_HL = 2'd2, PAIR_SP_AF = 2'd3;

	localparam alu_op_t ALU_ADD = 4'd0, ALU_ADC = 4'd1, ALU_SUB = 4'd2, ALU_SBC = 4'd3;
	localparam alu_op_t ALU_AND = 4'd4, ALU_XOR = 4'd5, ALU_OR = 4'd6, ALU_CP = 4'd7;
	localparam alu_op_t ALU_INC = 4'd8, ALU_DEC = 4'd9;

	localparam instr_t I_NOP = 4'd0, I_HALT = 4'd1, I_LD_R_D8 = 4'd2, I_LD_R_R = 4'd3;
	localparam instr_t I_LD_RR_D16 = 4'd4, I_ALU_R = 4'd5, I_ALU_D8 = 4'd6, I_INCDEC = 4'd7;
	localparam instr_t I_JP = 4'd8, I_JR = 4'd9, I_LDH_A8_A = 4'd10, I_PUSH = 4'd11;

	localparam cond_t COND_NZ = 3'd0, COND_Z = 3'd1, COND_NC = 3'd2, COND_C = 3'd3;
	localparam cond_t COND_ALWAYS = 3'd4;

	localparam addr_t RESET_PC = 16'h0000;
	localparam addr_t RESET_SP = 16'hFFFE;

	localparam byte_t RESET_A = 8'h11, RESET_F = 8'h80, RESET_B = 8'h00, RESET_C = 8'h00;
	localparam byte_t RESET_D = 8'hFF, RESET_E = 8'h56, RESET_H = 8'h00, RESET_L = 8'h0D;

	localparam byte_t HIGH_PAGE = 8'hFF;

	localparam int MCYCLE = 4;	// clocks per machine cycle
	localparam int FETCH_CLOCKS = 4;

endpackage

//--- source/gb_regfile.sv
// General registers B C D E H L A and flag register F.
// Byte, pair and masked flag writes; one combinational read port.
`timescale 1ns/1ps

module gb_regfile (
	input logic clock,
	input logic rst,
	gb_reg_if.rf rf
);
	import gb_pkg::*;

	byte_t  regs [8];	// slot REG_NONE stays unused
	flags_t flags;

	always_ff @(posedge clock) begin
		if (rst) begin
			regs[REG_B] <= RESET_B;
			regs[REG_C] <= RESET_C;
			regs[REG_D] <= RESET_D;
			regs[REG_E] <= RESET_E;
			regs[REG_H] <= RESET_H;
			regs[REG_L] <= RESET_L;
			regs[REG_A] <= RESET_A;
			flags <= RESET_F[7:4];
		end else begin
			if (rf.wr_en && rf.wr_sel != REG_NONE)
				regs[rf.wr_sel] <= rf.wr_data;
			if (rf.pair_en && rf.pair_sel != PAIR_SP_AF) begin	// SP lives in the sequencer
				regs[{rf.pair_sel, 1'b0}] <= rf.pair_hi;
				regs[{rf.pair_sel, 1'b1}] <= rf.pair_lo;
			end
			if (rf.flags_en)
				flags <= (flags & ~rf.flags_mask) | (rf.flags_wr & rf.flags_mask);
		end
	end

	// REG_NONE reads F, low nibble zero, for push AF
	assign rf.rd_data = (rf.rd_sel == REG_NONE) ? {flags, 4'b0000} : regs[rf.rd_sel];
	assign rf.flags = flags;
	assign rf.acc = regs[REG_A];

endmodule

//--- source/gb_sequencer.sv
// Instruction sequencer: fetch, fixed-length execution steps, PC, SP and bus control.
// Every instruction takes a whole number of 4-clock machine cycles.
`timescale 1ns/1ps

module gb_sequencer (
	input  logic              clock,
	input  logic              rst,
	input  gb_pkg::instr_t    instr,
	input  gb_pkg::reg_sel_t  dst,
	input  gb_pkg::reg_sel_t  src,
	input  gb_pkg::pair_sel_t pair,
	input  gb_pkg::alu_op_t   alu_op,
	input  gb_pkg::cond_t     cond,
	output gb_pkg::byte_t     opcode,
	gb_reg_if.seq             regs,
	gb_alu_if.seq             alu,
	output gb_pkg::addr_t     addr,
	input  gb_pkg::byte_t     data_in,
	output gb_pkg::byte_t     data_out,
	output logic              re,
	output logic              we,
	output gb_pkg::addr_t     pc,
	output logic              halted
);
	import gb_pkg::*;

	seq_state_t state;
	cycle_cnt_t cnt, step, exec_len;
	addr_t      sp;
	byte_t      imm_lo;
	logic       taken, cond_ok, is_jump, short_op, wb_fetch;

	assign halted = state == ST_HALT;
	assign is_jump = instr == I_JP || instr == I_JR;
	assign step = (taken && is_jump) ? cnt - 5'd4 : cnt;	// taken jumps run one cycle longer
	assign short_op = instr == I_NOP || instr == I_LD_R_R || instr == I_ALU_R
		|| instr == I_INCDEC;
	assign wb_fetch = state == ST_FETCH && cnt == 5'd0;

	always_comb begin
		case (cond)
			COND_NZ: cond_ok = !regs.flags[3];
			COND_Z:  cond_ok = regs.flags[3];
			COND_NC: cond_ok = !regs.flags[0];
			COND_C:  cond_ok = regs.flags[0];
			default: cond_ok = 1'b1;
		endcase
		case (instr)
			I_LD_R_D8, I_ALU_D8:     exec_len = cycle_cnt_t'(MCYCLE - 1);
			I_LD_RR_D16, I_LDH_A8_A: exec_len = cycle_cnt_t'(2 * MCYCLE - 1);
			I_PUSH:                  exec_len = cycle_cnt_t'(3 * MCYCLE - 1);
			I_JP:    exec_len = cycle_cnt_t'((cond_ok ? 3 : 2) * MCYCLE - 1);
			default: exec_len = cycle_cnt_t'((cond_ok ? 2 : 1) * MCYCLE - 1);	// jr
		endcase
	end

	// register file and ALU controls
	always_comb begin
		regs.rd_sel = (instr == I_INCDEC) ? dst : src;
		if (instr == I_PUSH) begin
			if (pair == PAIR_SP_AF)
				regs.rd_sel = (cnt >= 5'd8) ? REG_A : REG_NONE;
			else
				regs.rd_sel = {pair, cnt < 5'd8};
		end
		alu.a = (instr == I_INCDEC) ? regs.rd_data : regs.acc;
		alu.b = (instr == I_ALU_D8) ? data_in : regs.rd_data;
		alu.op = alu_op;
		alu.carry_in = regs.flags[0];
		regs.wr_sel = dst;
		regs.wr_data = alu.result;
		regs.wr_en = 1'b0;
		regs.pair_sel = pair;
		regs.pair_hi = data_in;
		regs.pair_lo = imm_lo;
		regs.pair_en = state == ST_EXEC && instr == I_LD_RR_D16 && cnt == 5'd1
			&& pair != PAIR_SP_AF;
		regs.flags_wr = alu.znhc;
		regs.flags_mask = (instr == I_INCDEC) ? 4'b1110 : 4'b1111;
		regs.flags_en = 1'b0;
		if (wb_fetch && instr == I_LD_R_R) begin
			regs.wr_data = regs.rd_data;
			regs.wr_en = 1'b1;
		end
		if (wb_fetch && instr == I_INCDEC) begin
			regs.wr_en = 1'b1;
			regs.flags_en = 1'b1;
		end
		if ((wb_fetch && instr == I_ALU_R)
			|| (state == ST_EXEC && cnt == 5'd0 && instr == I_ALU_D8)) begin
			regs.wr_sel = REG_A;
			regs.wr_en = alu_op != ALU_CP;	// cp only sets flags
			regs.flags_en = 1'b1;
		end
		if (state == ST_EXEC && cnt == 5'd1 && instr == I_LD_R_D8) begin
			regs.wr_data = data_in;
			regs.wr_en = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= ST_EXEC;	// first edge launches the fetch at RESET_PC
			cnt <= '0;
			opcode <= 8'h00;
			pc <= RESET_PC;
			sp <= RESET_SP;
			addr <= RESET_PC;
			re <= 1'b0;
			we <= 1'b0;
			taken <= 1'b0;
		end else begin
			case (state)
				ST_FETCH: begin
					cnt <= cnt - 5'd1;
					if (cnt == 5'd2) begin	// two clocks after re rose
						opcode <= data_in;
						re <= 1'b0;
					end
					if (cnt == 5'd0) begin
						taken <= cond_ok;
						if (instr == I_HALT) begin
							state <= ST_HALT;
						end else if (short_op) begin
							cnt <= cycle_cnt_t'(FETCH_CLOCKS - 1);
							addr <= pc;
							re <= 1'b1;
							pc <= pc + 16'd1;
						end else begin
							state <= ST_EXEC;
							cnt <= exec_len;
						end
					end
				end
				ST_EXEC: begin
					cnt <= cnt - 5'd1;
					case (instr)
						I_LD_R_D8, I_ALU_D8, I_JR: begin
							if (step == 5'd3) begin
								addr <= pc;
								re <= 1'b1;
								pc <= pc + 16'd1;
							end
							if (step == 5'd1) begin
								re <= 1'b0;
								if (instr == I_JR && taken)
									pc <= pc + {{8{data_in[7]}}, data_in};
							end
						end
						I_LD_RR_D16, I_JP, I_LDH_A8_A: begin
							if (step == 5'd7 || (step == 5'd3 && instr != I_LDH_A8_A)) begin
								addr <= pc;
								re <= 1'b1;
								pc <= pc + 16'd1;
							end
							if (step == 5'd5) begin
								imm_lo <= data_in;
								re <= 1'b0;
								if (instr == I_LDH_A8_A) begin
									addr <= {HIGH_PAGE, data_in};
									data_out <= regs.acc;
									we <= 1'b1;
								end
							end
							if (step == 5'd3 && instr == I_LDH_A8_A)
								we <= 1'b0;
							if (step == 5'd1) begin
								re <= 1'b0;
								if (instr == I_LD_RR_D16 && pair == PAIR_SP_AF)
									sp <= {data_in, imm_lo};
								if (instr == I_JP && taken)
									pc <= {data_in, imm_lo};
							end
						end
						I_PUSH: begin
							if (cnt == 5'd11 || cnt == 5'd7) begin	// high byte first
								sp <= sp - 16'd1;
								addr <= sp - 16'd1;
								data_out <= regs.rd_data;
								we <= 1'b1;
							end
							if (cnt == 5'd9 || cnt == 5'd5)
								we <= 1'b0;
						end
						default: ;
					endcase
					if (cnt == 5'd0) begin	// launch next fetch
						state <= ST_FETCH;
						cnt <= cycle_cnt_t'(FETCH_CLOCKS - 1);
						addr <= pc;
						re <= 1'b1;
						pc <= pc + 16'd1;
					end
				end
				default: ;	// halted until reset
			endcase
		end
	end

endmodule

//--- vlog.f
+incdir+sim
source/gb_pkg.sv
source/gb_ifs.sv
source/gb_alu.sv
source/gb_regfile.sv
source/gb_decoder.sv
source/gb_sequencer.sv
source/gb_cpu.sv
sim/tb_gb_cpu.sv
